// ==== hdl/fp_format_pkg.sv ====
// ieee single-precision format
package fp_format_pkg;

    localparam int EXP_W = 8;
    localparam int MAN_W = 23;

    // largest biased exponent of a finite number
    localparam int EXP_MAX_FINITE = 254;

    // all-ones exponent marks infinity and NaN
    localparam logic [EXP_W-1:0] EXP_SPECIAL = '1;

    // top mantissa bit set means quiet NaN
    localparam int QUIET_BIT = MAN_W - 1;

    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exponent;
        logic [MAN_W-1:0] mantissa;
    } fp32_t;

    // result of invalid operations
    localparam fp32_t QNAN_DEFAULT = 32'h7FC0_0000;

endpackage

// ==== hdl/addsub_pkg.sv ====
// add/sub pipeline stage types
package addsub_pkg;

    // guard, round and sticky below the mantissa
    localparam int GRS_W = 3;

    // hidden bit, mantissa, grs
    localparam int SIG_W = 1 + fp_format_pkg::MAN_W + GRS_W;

    // forwarded unchanged through every stage
    typedef struct packed {
        logic                 valid;
        logic                 special;
        fp_format_pkg::fp32_t special_result;
        logic                 invalid;
    } side_t;

    typedef struct packed {
        side_t                side;
        fp_format_pkg::fp32_t a;
        fp_format_pkg::fp32_t b;
    } classify_t;

    typedef struct packed {
        side_t                           side;
        logic                            sign;
        logic [fp_format_pkg::EXP_W-1:0] exponent;
        logic [SIG_W-1:0]                big_sig;
        // sticky already folded into bit 0
        logic [SIG_W-1:0]                small_sig;
        logic                            subtract;
    } align_t;

    typedef struct packed {
        side_t                           side;
        logic                            sign;
        logic [fp_format_pkg::EXP_W-1:0] exponent;
        logic [SIG_W:0]                  sum;
        logic                            subtract;
        logic                            exact_zero;
    } sum_t;

endpackage

// ==== hdl/norm_if.sv ====
// normalizer to rounder link
`timescale 1ns/1ps

interface norm_if;
    logic                              sign;
    // extra top bits hold overflow and negative exponents
    logic signed [fp_format_pkg::EXP_W+1:0] exponent;
    logic [fp_format_pkg::MAN_W-1:0]   mantissa;
    logic                              guard;
    logic                              round;
    logic                              sticky;
    logic                              exact_zero;
    addsub_pkg::side_t                 side;

    modport src (output sign, exponent, mantissa, guard, round, sticky, exact_zero, side);
    modport dst (input sign, exponent, mantissa, guard, round, sticky, exact_zero, side);
endinterface

// ==== hdl/stage_reg.sv ====
// generic pipeline register
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    output payload_t q
);

    // loads every cycle, no enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

// ==== hdl/fp_classify.sv ====
// operand classification stage
`timescale 1ns/1ps

module fp_classify (
    input  logic                  valid_in,
    input  fp_format_pkg::fp32_t  in_a,
    input  fp_format_pkg::fp32_t  in_b,
    output addsub_pkg::classify_t staged
);

    typedef struct packed {
        logic zero;
        logic denorm;
        logic inf;
        logic qnan;
        logic snan;
    } op_class_t;

    op_class_t ca;
    op_class_t cb;
    logic      a_flush;
    logic      b_flush;

    function automatic op_class_t classify_op(input fp_format_pkg::fp32_t op);
        op_class_t c;
        logic      exp_ones;
        logic      man_zero;
        exp_ones = (op.exponent == fp_format_pkg::EXP_SPECIAL);
        man_zero = (op.mantissa == '0);
        c.zero   = (op.exponent == '0) && man_zero;
        c.denorm = (op.exponent == '0) && !man_zero;
        c.inf    = exp_ones && man_zero;
        c.qnan   = exp_ones && op.mantissa[fp_format_pkg::QUIET_BIT];
        c.snan   = exp_ones && !man_zero && !op.mantissa[fp_format_pkg::QUIET_BIT];
        return c;
    endfunction

    assign ca = classify_op(in_a);
    assign cb = classify_op(in_b);

    // denormals are flushed and behave as zero
    assign a_flush = ca.zero || ca.denorm;
    assign b_flush = cb.zero || cb.denorm;

    always_comb begin
        staged.a                 = in_a;
        staged.b                 = in_b;
        staged.side.valid        = valid_in;
        staged.side.invalid      = ca.snan || cb.snan ||
                                   (ca.inf && cb.inf && (in_a.sign != in_b.sign));
        staged.side.special      = 1'b1;
        staged.side.special_result = '0;

        // priority order matters, NaNs first
        if (ca.qnan) begin
            staged.side.special_result = in_a;
        end else if (cb.qnan) begin
            staged.side.special_result = in_b;
        end else if (ca.snan) begin
            staged.side.special_result = in_a;
            staged.side.special_result.mantissa[fp_format_pkg::QUIET_BIT] = 1'b1;
        end else if (cb.snan) begin
            staged.side.special_result = in_b;
            staged.side.special_result.mantissa[fp_format_pkg::QUIET_BIT] = 1'b1;
        end else if (ca.inf && cb.inf) begin
            staged.side.special_result = (in_a.sign == in_b.sign) ?
                                         in_a : fp_format_pkg::QNAN_DEFAULT;
        end else if (ca.inf) begin
            staged.side.special_result = in_a;
        end else if (cb.inf) begin
            staged.side.special_result = in_b;
        end else if (a_flush && b_flush) begin
            // opposite signed zeros give +0
            staged.side.special_result.sign = in_a.sign && in_b.sign;
        end else if (a_flush) begin
            staged.side.special_result = in_b;
        end else if (b_flush) begin
            staged.side.special_result = in_a;
        end else begin
            staged.side.special = 1'b0;
        end
    end

    always_comb begin
        if (staged.side.valid) begin
            assert final (!staged.side.invalid || staged.side.special)
                else $error("invalid operation without a special result");
        end
    end

endmodule

// ==== hdl/fp_align.sv ====
// exponent alignment stage
`timescale 1ns/1ps

module fp_align (
    input  addsub_pkg::classify_t staged,
    output addsub_pkg::align_t    aligned
);

    localparam int SIG_W = addsub_pkg::SIG_W;

    fp_format_pkg::fp32_t            big_op;
    fp_format_pkg::fp32_t            small_op;
    logic [fp_format_pkg::EXP_W-1:0] exp_diff;
    logic [SIG_W-1:0]                small_sig;
    logic [SIG_W-1:0]                shifted;
    logic                            sticky;

    always_comb begin
        // order by exponent, then by mantissa; a wins ties
        if ((staged.a.exponent > staged.b.exponent) ||
            ((staged.a.exponent == staged.b.exponent) &&
             (staged.a.mantissa >= staged.b.mantissa))) begin
            big_op   = staged.a;
            small_op = staged.b;
        end else begin
            big_op   = staged.b;
            small_op = staged.a;
        end

        exp_diff  = big_op.exponent - small_op.exponent;
        small_sig = {1'b1, small_op.mantissa, {addsub_pkg::GRS_W{1'b0}}};

        // shifts of SIG_W or more clear the word, only sticky survives
        shifted = small_sig >> exp_diff;
        sticky  = |(small_sig & ~({SIG_W{1'b1}} << exp_diff));

        aligned.side      = staged.side;
        aligned.sign      = big_op.sign;
        aligned.exponent  = big_op.exponent;
        aligned.big_sig   = {1'b1, big_op.mantissa, {addsub_pkg::GRS_W{1'b0}}};
        aligned.small_sig = {shifted[SIG_W-1:1], shifted[0] | sticky};
        aligned.subtract  = staged.a.sign ^ staged.b.sign;
    end

    always_comb begin
        if (staged.side.valid && !staged.side.special) begin
            assert final (big_op.exponent >= small_op.exponent)
                else $error("larger operand has the smaller exponent");
        end
    end

endmodule

// ==== hdl/mant_addsub.sv ====
// significand add/subtract stage
`timescale 1ns/1ps

module mant_addsub (
    input  addsub_pkg::align_t aligned,
    output addsub_pkg::sum_t   summed
);

    logic [addsub_pkg::SIG_W:0] total;

    // big_sig >= small_sig, so the difference never goes negative
    always_comb begin
        if (aligned.subtract) begin
            total = {1'b0, aligned.big_sig} - {1'b0, aligned.small_sig};
        end else begin
            total = {1'b0, aligned.big_sig} + {1'b0, aligned.small_sig};
        end
    end

    always_comb begin
        summed.side       = aligned.side;
        summed.sign       = aligned.sign;
        summed.exponent   = aligned.exponent;
        summed.sum        = total;
        summed.subtract   = aligned.subtract;
        // x - x cancels completely
        summed.exact_zero = aligned.subtract && (aligned.big_sig == aligned.small_sig);
    end

endmodule

// ==== hdl/fp_normalize.sv ====
// post-add normalization
`timescale 1ns/1ps

module fp_normalize (
    input  addsub_pkg::sum_t summed,
    norm_if.src              nrm
);

    localparam int SIG_W = addsub_pkg::SIG_W;
    localparam int EXP_W = fp_format_pkg::EXP_W;
    localparam int LZ_W  = $clog2(SIG_W + 1);

    logic [LZ_W-1:0]          lz;
    logic [SIG_W-1:0]         norm_sig;
    logic                     shifted_out;
    logic signed [EXP_W+1:0]  exp_adj;

    // leading zero count, the highest set bit wins
    always_comb begin
        lz = LZ_W'(SIG_W);
        for (int i = 0; i < SIG_W; i++) begin
            if (summed.sum[i]) begin
                lz = LZ_W'(SIG_W - 1 - i);
            end
        end
    end

    always_comb begin
        if (!summed.subtract && summed.sum[SIG_W]) begin
            // carry out, move right by one
            norm_sig    = summed.sum[SIG_W:1];
            shifted_out = summed.sum[0];
            exp_adj     = $signed({2'b00, summed.exponent}) + 10'sd1;
        end else begin
            norm_sig    = summed.sum[SIG_W-1:0] << lz;
            shifted_out = 1'b0;
            exp_adj     = $signed({2'b00, summed.exponent}) -
                          $signed({{(EXP_W+2-LZ_W){1'b0}}, lz});
        end

        nrm.sign       = summed.sign;
        nrm.exponent   = exp_adj;
        nrm.mantissa   = norm_sig[SIG_W-2:addsub_pkg::GRS_W];
        nrm.guard      = norm_sig[2];
        nrm.round      = norm_sig[1];
        nrm.sticky     = norm_sig[0] | shifted_out;
        nrm.exact_zero = summed.exact_zero;
        nrm.side       = summed.side;
    end

    always_comb begin
        if (summed.side.valid && !summed.side.special && !summed.exact_zero) begin
            assert final (norm_sig[SIG_W-1])
                else $error("hidden bit clear after normalization");
        end
    end

endmodule

// ==== hdl/fp_round_pack.sv ====
// rounding and result packing
`timescale 1ns/1ps

module fp_round_pack (
    input  logic        clk,
    input  logic        rst,
    norm_if.dst         nrm,
    output logic [31:0] result,
    output logic        overflow,
    output logic        inexact,
    output logic        invalid_operation,
    output logic        valid_out
);

    localparam int EXP_W = fp_format_pkg::EXP_W;
    localparam int MAN_W = fp_format_pkg::MAN_W;

    logic                    round_up;
    logic                    grs_any;
    logic [MAN_W:0]          man_rnd;
    logic signed [EXP_W+1:0] exp_rnd;
    fp_format_pkg::fp32_t    next_result;
    logic                    next_overflow;
    logic                    next_inexact;

    // nearest even, ties go to the even mantissa
    assign round_up = nrm.guard & (nrm.round | nrm.sticky | nrm.mantissa[0]);
    assign grs_any  = nrm.guard | nrm.round | nrm.sticky;
    assign man_rnd  = {1'b0, nrm.mantissa} + {{MAN_W{1'b0}}, round_up};

    // mantissa wrapped to zero on carry, so only the exponent moves
    assign exp_rnd = nrm.exponent + $signed({{(EXP_W+1){1'b0}}, man_rnd[MAN_W]});

    always_comb begin
        next_result   = '0;
        next_overflow = 1'b0;
        next_inexact  = 1'b0;
        if (nrm.side.special) begin
            next_result = nrm.side.special_result;
        end else if (nrm.exact_zero) begin
            next_result = '0;
        end else if (exp_rnd > fp_format_pkg::EXP_MAX_FINITE) begin
            next_result.sign     = nrm.sign;
            next_result.exponent = fp_format_pkg::EXP_SPECIAL;
            next_overflow        = 1'b1;
            next_inexact         = 1'b1;
        end else if (exp_rnd <= 0) begin
            // tiny results flush to a signed zero
            next_result.sign = nrm.sign;
            next_inexact     = grs_any;
        end else begin
            next_result.sign     = nrm.sign;
            next_result.exponent = exp_rnd[EXP_W-1:0];
            next_result.mantissa = man_rnd[MAN_W-1:0];
            next_inexact         = grs_any;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result            <= '0;
            overflow          <= 1'b0;
            inexact           <= 1'b0;
            invalid_operation <= 1'b0;
            valid_out         <= 1'b0;
        end else begin
            result            <= next_result;
            overflow          <= next_overflow;
            inexact           <= next_inexact;
            invalid_operation <= nrm.side.invalid;
            valid_out         <= nrm.side.valid;
        end
    end

    a_overflow_inexact: assert property (@(posedge clk) disable iff (rst)
        overflow |-> inexact)
        else $error("overflow raised without inexact");

endmodule

// ==== hdl/fp_addsub_pipeline.sv ====
// pipelined fp32 adder/subtractor
`timescale 1ns/1ps

module fp_addsub_pipeline (
    input  logic        clk,
    input  logic        rst,
    input  logic        valid_in,
    input  logic [31:0] in_a,
    input  logic [31:0] in_b,
    output logic [31:0] result,
    output logic        overflow,
    output logic        inexact,
    output logic        invalid_operation,
    output logic        valid_out
);

    addsub_pkg::classify_t s1_classify;
    addsub_pkg::classify_t s2_classify;
    addsub_pkg::align_t    s2_align;
    addsub_pkg::align_t    s3_align;
    addsub_pkg::sum_t      s3_sum;
    addsub_pkg::sum_t      s4_sum;

    norm_if i_norm ();

    // stage 1
    fp_classify i_classify (
        .valid_in (valid_in),
        .in_a     (in_a),
        .in_b     (in_b),
        .staged   (s1_classify)
    );

    stage_reg #(.payload_t(addsub_pkg::classify_t)) i_s2 (
        .clk (clk), .rst (rst), .d (s1_classify), .q (s2_classify)
    );

    // stage 2
    fp_align i_align (.staged (s2_classify), .aligned (s2_align));

    stage_reg #(.payload_t(addsub_pkg::align_t)) i_s3 (
        .clk (clk), .rst (rst), .d (s2_align), .q (s3_align)
    );

    // stage 3
    mant_addsub i_addsub (.aligned (s3_align), .summed (s3_sum));

    stage_reg #(.payload_t(addsub_pkg::sum_t)) i_s4 (
        .clk (clk), .rst (rst), .d (s3_sum), .q (s4_sum)
    );

    // stage 4, normalize then round into the output registers
    fp_normalize i_normalize (.summed (s4_sum), .nrm (i_norm.src));

    fp_round_pack i_round (
        .clk               (clk),
        .rst               (rst),
        .nrm               (i_norm.dst),
        .result            (result),
        .overflow          (overflow),
        .inexact           (inexact),
        .invalid_operation (invalid_operation),
        .valid_out         (valid_out)
    );

endmodule

// ==== tests/tb_fp_addsub.sv ====
// fp32 add/sub pipeline testbench
`timescale 1ns/1ps

module tb_fp_addsub;

    localparam int LATENCY     = 4;
    localparam int DRAIN_LIMIT = 40;

    typedef struct packed {
        fp_format_pkg::fp32_t result;
        logic                 overflow;
        logic                 inexact;
        logic                 invalid;
        int                   due_cyc;
    } expect_t;

    logic                 clk;
    logic                 rst;
    logic                 valid_in;
    fp_format_pkg::fp32_t in_a;
    fp_format_pkg::fp32_t in_b;
    logic [31:0]          result;
    logic                 overflow;
    logic                 inexact;
    logic                 invalid_operation;
    logic                 valid_out;

    expect_t pending[$];
    expect_t done_op;
    int      cyc = 0;
    int      errors = 0;
    int      timeouts = 0;
    integer  seed;

    fp_addsub_pipeline i_dut (
        .clk               (clk),
        .rst               (rst),
        .valid_in          (valid_in),
        .in_a              (in_a),
        .in_b              (in_b),
        .result            (result),
        .overflow          (overflow),
        .inexact           (inexact),
        .invalid_operation (invalid_operation),
        .valid_out         (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_word(input string name, input fp_format_pkg::fp32_t expected,
                              input fp_format_pkg::fp32_t actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_cycle(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("ERR %0t %s expected cycle %0d got cycle %0d",
                     $time, name, expected, actual);
        end
    endtask

    // outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        if (!rst) begin
            if (valid_out) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("valid_out high at %0t with no operation pending", $time);
                end else begin
                    done_op = pending.pop_front();
                    check_cycle("latency", done_op.due_cyc, cyc);
                    check_word("result", done_op.result, result);
                    check_flag("overflow", done_op.overflow, overflow);
                    check_flag("inexact", done_op.inexact, inexact);
                    check_flag("invalid_operation", done_op.invalid, invalid_operation);
                end
            end else if (pending.size() != 0 && cyc >= pending[0].due_cyc) begin
                done_op = pending.pop_front();
                errors++;
                $display("valid_out never rose for the operation due at cycle %0d",
                         done_op.due_cyc);
            end
        end
    end

    task automatic issue(input fp_format_pkg::fp32_t a, input fp_format_pkg::fp32_t b,
                         input fp_format_pkg::fp32_t res, input logic ovf,
                         input logic inx, input logic inv);
        expect_t e;
        @(negedge clk);
        valid_in = 1'b1;
        in_a     = a;
        in_b     = b;
        e.result   = res;
        e.overflow = ovf;
        e.inexact  = inx;
        e.invalid  = inv;
        // result register loads on rising edge cyc + LATENCY
        e.due_cyc  = cyc + LATENCY;
        pending.push_back(e);
    endtask

    task automatic drain(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        valid_in = 1'b0;
        while (pending.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (pending.size() != 0) begin
            timeouts++;
            $display("timeout, %s results never arrived", what);
            pending.delete();
        end
    endtask

    // only normal operands reach the model
    function automatic real to_real(input fp_format_pkg::fp32_t x);
        return $bitstoreal({x.sign, 11'(x.exponent) + 11'd896, x.mantissa, 29'b0});
    endfunction

    // exact real sum rounded once to fp32 nearest even
    task automatic model_sum(input fp_format_pkg::fp32_t a, input fp_format_pkg::fp32_t b,
                             output fp_format_pkg::fp32_t sum, output logic inx);
        logic [63:0] d;
        logic        guard_bit;
        logic        rest;
        d   = $realtobits(to_real(a) + to_real(b));
        sum = '0;
        inx = 1'b0;
        if (d[62:0] != '0) begin
            sum.sign     = d[63];
            sum.exponent = 8'(d[62:52] - 11'd896);
            sum.mantissa = d[51:29];
            guard_bit    = d[28];
            rest         = |d[27:0];
            inx          = guard_bit | rest;
            if (guard_bit && (rest || sum.mantissa[0])) begin
                sum = sum + 32'd1;
            end
        end
    endtask

    task automatic random_operand(input int exp_val, output fp_format_pkg::fp32_t op);
        logic [31:0] rnd;
        rnd         = $random(seed);
        op.sign     = rnd[0];
        op.exponent = 8'(exp_val);
        op.mantissa = rnd[31:9];
    endtask

    task automatic test_reset_state();
        check_flag("valid_out", 1'b0, valid_out);
        check_flag("overflow", 1'b0, overflow);
        check_flag("inexact", 1'b0, inexact);
        check_flag("invalid_operation", 1'b0, invalid_operation);
        check_word("result", 32'h0000_0000, result);
    endtask

    task automatic test_special_cases();
        issue(32'h7FC1_2345, 32'h3F80_0000, 32'h7FC1_2345, 1'b0, 1'b0, 1'b0);
        issue(32'h7F81_2345, 32'h3F80_0000, 32'h7FC1_2345, 1'b0, 1'b0, 1'b1);
        issue(32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000, 1'b0, 1'b0, 1'b1);
        issue(32'h7F80_0000, 32'h3F80_0000, 32'h7F80_0000, 1'b0, 1'b0, 1'b0);
        drain("special case");
    endtask

    task automatic test_zero_flush();
        issue(32'h0000_0001, 32'h3FC0_0000, 32'h3FC0_0000, 1'b0, 1'b0, 1'b0);
        issue(32'h0000_0000, 32'h8000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
        issue(32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0, 1'b0);
        drain("zero and denormal");
    endtask

    task automatic test_exact_sums();
        issue(32'h3F80_0000, 32'h4000_0000, 32'h4040_0000, 1'b0, 1'b0, 1'b0);
        issue(32'h4040_0000, 32'hBF80_0000, 32'h4000_0000, 1'b0, 1'b0, 1'b0);
        issue(32'h4123_4567, 32'hC123_4567, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
        drain("exact arithmetic");
    endtask

    task automatic test_rounding();
        logic [31:0]          rnd;
        int                   ea;
        int                   eb;
        fp_format_pkg::fp32_t a;
        fp_format_pkg::fp32_t b;
        fp_format_pkg::fp32_t res;
        logic                 inx;
        // a tie kept even and a tie rounded up to even
        issue(32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000, 1'b0, 1'b1, 1'b0);
        issue(32'h3F80_0000, 32'h3440_0000, 32'h3F80_0002, 1'b0, 1'b1, 1'b0);
        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            ea  = 64 + int'(rnd[7:0]) % 127;
            rnd = $random(seed);
            eb  = ea + int'(rnd[7:0]) % 41 - 20;
            if (eb < 64) eb = 64;
            if (eb > 190) eb = 190;
            random_operand(ea, a);
            random_operand(eb, b);
            model_sum(a, b, res, inx);
            issue(a, b, res, 1'b0, inx, 1'b0);
        end
        drain("rounding");
    endtask

    task automatic test_overflow();
        issue(32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000, 1'b1, 1'b1, 1'b0);
        issue(32'hFF7F_FFFF, 32'hFF7F_FFFF, 32'hFF80_0000, 1'b1, 1'b1, 1'b0);
        drain("overflow");
    endtask

    // back-to-back 2^k + 2^k with distinct answers to expose reordering
    task automatic test_throughput();
        for (int k = 0; k < 8; k++) begin
            issue({1'b0, 8'(127 + k), 23'd0}, {1'b0, 8'(127 + k), 23'd0},
                  {1'b0, 8'(128 + k), 23'd0}, 1'b0, 1'b0, 1'b0);
        end
        drain("throughput");
    endtask

    task automatic report_counts();
        $display("errors %0d, timeouts %0d", errors, timeouts);
    endtask

    initial begin
        seed     = 32'h051b_7243;
        rst      = 1'b1;
        // a live overflowing operation held during reset must not leak out
        valid_in = 1'b1;
        in_a     = 32'h7F7F_FFFF;
        in_b     = 32'h7F7F_FFFF;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst      = 1'b0;
        valid_in = 1'b0;
        in_a     = '0;
        in_b     = '0;
        @(negedge clk);
        test_reset_state();
        test_special_cases();
        test_zero_flush();
        test_exact_sums();
        test_rounding();
        test_overflow();
        test_throughput();
        report_counts();
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // whole-run limit
    initial begin
        #1_000_000;
        timeouts++;
        $display("simulation ran past its time limit");
        report_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== fp_addsub_pipeline.f ====
hdl/fp_format_pkg.sv
hdl/addsub_pkg.sv
hdl/norm_if.sv
hdl/stage_reg.sv
hdl/fp_classify.sv
hdl/fp_align.sv
hdl/mant_addsub.sv
hdl/fp_normalize.sv
hdl/fp_round_pack.sv
hdl/fp_addsub_pipeline.sv
tests/tb_fp_addsub.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the fp32 add/sub pipeline testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 -Mdir obj_dir \
    --top-module tb_fp_addsub -f fp_addsub_pipeline.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_fp_addsub > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
exit 1
